//--- all.f
source/fpga_support_pkg.sv
source/board_input_sync.sv
source/key_debouncer.sv
source/reset_request_pulser.sv
source/heartbeat_led.sv
source/fpga_support_top.sv
testbench/tb_fpga_support.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, and pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing -f all.f --top-module tb_fpga_support -o tb_fpga_support; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_fpga_support > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

//--- source/board_input_sync.sv
/* brings the asynchronous board keys, switches and reset requests into fpga_clk_50
   plain flop chains, so multi-bit inputs may skew by one cycle between bits */
`timescale 1ns/10ps
`default_nettype none

module board_input_sync
(
    input  logic                                          fpga_clk_50,
    input  logic                                          hps_fpga_reset_n,
    input  logic [fpga_support_pkg::KEY_COUNT-1:0]        key,
    input  logic [fpga_support_pkg::SWITCH_COUNT-1:0]     sw,
    input  logic [fpga_support_pkg::RESET_REQ_COUNT-1:0]  reset_req,
    output logic [fpga_support_pkg::KEY_COUNT-1:0]        key_sync,
    output logic [fpga_support_pkg::SWITCH_COUNT-1:0]     sw_sync,
    output logic [fpga_support_pkg::RESET_REQ_COUNT-1:0]  reset_req_sync
);

    // stage 0 samples the pin, last stage is the clean copy
    logic [fpga_support_pkg::KEY_COUNT-1:0]       key_stage [fpga_support_pkg::SYNC_STAGES];
    logic [fpga_support_pkg::SWITCH_COUNT-1:0]    sw_stage  [fpga_support_pkg::SYNC_STAGES];
    logic [fpga_support_pkg::RESET_REQ_COUNT-1:0] req_stage [fpga_support_pkg::SYNC_STAGES];

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            for (int s = 0; s < fpga_support_pkg::SYNC_STAGES; s++)
            begin
                key_stage[s] <= '1;  // keys idle high, no false press
                sw_stage[s]  <= '0;
                req_stage[s] <= '0;  // no request seen out of reset
            end
        end
        else
        begin
            key_stage[0] <= key;        // first flop, may go metastable
            sw_stage[0]  <= sw;
            req_stage[0] <= reset_req;
            for (int s = 1; s < fpga_support_pkg::SYNC_STAGES; s++)
            begin
                key_stage[s] <= key_stage[s-1];  // shift down the chain
                sw_stage[s]  <= sw_stage[s-1];
                req_stage[s] <= req_stage[s-1];
            end
        end
    end

    assign key_sync       = key_stage[fpga_support_pkg::SYNC_STAGES-1];
    assign sw_sync        = sw_stage[fpga_support_pkg::SYNC_STAGES-1];
    assign reset_req_sync = req_stage[fpga_support_pkg::SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- source/fpga_support_pkg.sv
/* widths and default timing for the fabric logic around the processor subsystem
   default timing assumes fpga_clk_50 runs at 50 MHz */
`default_nettype none

package fpga_support_pkg;

    // ====================================================================
    // board widths
    // ====================================================================
    localparam int KEY_COUNT       = 4;   // push keys, active low
    localparam int SWITCH_COUNT    = 10;  // slide switches
    localparam int LED_COUNT       = 10;  // red leds
    localparam int RESET_REQ_COUNT = 3;   // 0 cold, 1 warm, 2 debug
    localparam int STM_EVENT_WIDTH = 28;  // trace event bus into the hps

    // ====================================================================
    // timing
    // ====================================================================
    localparam int SYNC_STAGES                   = 2;         // flops per sync chain
    localparam int DEFAULT_DEBOUNCE_CYCLES       = 50000;     // 1 ms
    localparam int DEFAULT_HEARTBEAT_HALF_PERIOD = 25000000;  // 0.5 s per blink phase

    // pulse length per reset channel, same order as reset_req
    localparam int RESET_PULSE_CYCLES [RESET_REQ_COUNT] = '{6, 2, 32};

    // bits needed to hold the value cycles itself
    function automatic int counter_width(input int cycles);
        int width;
        width = (cycles < 1) ? 1 : $clog2(cycles + 1);
        return width;
    endfunction

endpackage

`default_nettype wire

//--- source/fpga_support_top.sv
/* fabric glue next to the hps: key debounce, reset request pulses, heartbeat, trace word
   led_soft must already be in the fpga_clk_50 domain, it is not synchronized */
`timescale 1ns/10ps
`default_nettype none

module fpga_support_top
#(
    parameter int DEBOUNCE_CYCLES       = fpga_support_pkg::DEFAULT_DEBOUNCE_CYCLES,
    parameter int HEARTBEAT_HALF_PERIOD = fpga_support_pkg::DEFAULT_HEARTBEAT_HALF_PERIOD
)
(
    input  logic                                          fpga_clk_50,
    input  logic                                          hps_fpga_reset_n,
    input  logic [fpga_support_pkg::KEY_COUNT-1:0]        key,          // low when pressed
    input  logic [fpga_support_pkg::SWITCH_COUNT-1:0]     sw,
    input  logic [fpga_support_pkg::LED_COUNT-1:0]        led_soft,     // sw led register
    input  logic [fpga_support_pkg::RESET_REQ_COUNT-1:0]  reset_req,    // cold, warm, debug
    output logic [fpga_support_pkg::LED_COUNT-1:0]        ledr,
    output logic [fpga_support_pkg::KEY_COUNT-1:0]        key_clean,
    output logic [fpga_support_pkg::RESET_REQ_COUNT-1:0]  reset_pulse,  // to hps reset inputs
    output logic [fpga_support_pkg::STM_EVENT_WIDTH-1:0]  stm_hw_events
);

    // zero bits above the switch field in the trace word
    localparam int STM_PAD_W = fpga_support_pkg::STM_EVENT_WIDTH
                             - fpga_support_pkg::SWITCH_COUNT
                             - (fpga_support_pkg::LED_COUNT - 1)
                             - fpga_support_pkg::KEY_COUNT;

    logic [fpga_support_pkg::KEY_COUNT-1:0]       key_sync;
    logic [fpga_support_pkg::SWITCH_COUNT-1:0]    sw_sync;
    logic [fpga_support_pkg::RESET_REQ_COUNT-1:0] reset_req_sync;

    // ====================================================================
    // input sync and key debounce
    // ====================================================================
    board_input_sync u_input_sync
    (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .key              (key),
        .sw               (sw),
        .reset_req        (reset_req),
        .key_sync         (key_sync),
        .sw_sync          (sw_sync),
        .reset_req_sync   (reset_req_sync)
    );

    key_debouncer
    #(
        .WIDTH           (fpga_support_pkg::KEY_COUNT),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    )
    u_key_debouncer
    (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .key_sync         (key_sync),
        .key_clean        (key_clean)
    );

    // ====================================================================
    // reset request pulses, one pulser per channel
    // ====================================================================
    for (genvar ch = 0; ch < fpga_support_pkg::RESET_REQ_COUNT; ch++)
    begin : g_pulser
        reset_request_pulser
        #(
            .PULSE_CYCLES (fpga_support_pkg::RESET_PULSE_CYCLES[ch])  // 6 / 2 / 32
        )
        u_pulser
        (
            .fpga_clk_50      (fpga_clk_50),
            .hps_fpga_reset_n (hps_fpga_reset_n),
            .request          (reset_req_sync[ch]),
            .pulse            (reset_pulse[ch])
        );
    end

    heartbeat_led
    #(
        .HALF_PERIOD (HEARTBEAT_HALF_PERIOD)
    )
    u_heartbeat
    (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .led_soft         (led_soft),
        .ledr             (ledr)
    );

    // trace word, keys in the low bits, led 9 not traced
    assign stm_hw_events = {{STM_PAD_W{1'b0}},
                            sw_sync,
                            led_soft[fpga_support_pkg::LED_COUNT-2:0],
                            key_clean};

endmodule

`default_nettype wire

//--- source/heartbeat_led.sv
/* blinks led 0 so the board shows a running clock even with no software
   the blink is ORed in, software can still force led 0 on */
`timescale 1ns/10ps
`default_nettype none

module heartbeat_led
#(
    parameter int HALF_PERIOD = fpga_support_pkg::DEFAULT_HEARTBEAT_HALF_PERIOD
)
(
    input  logic                                    fpga_clk_50,
    input  logic                                    hps_fpga_reset_n,
    input  logic [fpga_support_pkg::LED_COUNT-1:0]  led_soft,
    output logic [fpga_support_pkg::LED_COUNT-1:0]  ledr
);

    localparam int CNT_W = fpga_support_pkg::counter_width(HALF_PERIOD - 1);
    localparam logic [CNT_W-1:0] CNT_WRAP = CNT_W'(HALF_PERIOD - 1);

    logic [CNT_W-1:0] div_cnt;  // free running divider
    logic             blink;    // heartbeat level

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            div_cnt <= '0;
            blink   <= 1'b0;  // led dark out of reset
        end
        else if (div_cnt == CNT_WRAP)
        begin
            div_cnt <= '0;      // wrap
            blink   <= ~blink;  // toggle every HALF_PERIOD cycles
        end
        else
        begin
            div_cnt <= div_cnt + CNT_W'(1);
        end
    end

    // upper leds straight from software
    assign ledr = {led_soft[fpga_support_pkg::LED_COUNT-1:1], led_soft[0] | blink};

endmodule

`default_nettype wire

//--- source/key_debouncer.sv
/* per-key debounce on already synchronized inputs
   a new level must hold DEBOUNCE_CYCLES cycles before key_clean follows */
`timescale 1ns/10ps
`default_nettype none

module key_debouncer
#(
    parameter int WIDTH           = fpga_support_pkg::KEY_COUNT,
    parameter int DEBOUNCE_CYCLES = fpga_support_pkg::DEFAULT_DEBOUNCE_CYCLES
)
(
    input  logic             fpga_clk_50,
    input  logic             hps_fpga_reset_n,
    input  logic [WIDTH-1:0] key_sync,
    output logic [WIDTH-1:0] key_clean
);

    localparam int CNT_W = fpga_support_pkg::counter_width(DEBOUNCE_CYCLES);

    // count value on the cycle the new level is accepted
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [CNT_W-1:0] stable_cnt [WIDTH];  // one counter per key

    // ====================================================================
    // stability counters
    // ====================================================================
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            key_clean <= '1;  // released
            for (int k = 0; k < WIDTH; k++)
            begin
                stable_cnt[k] <= '0;
            end
        end
        else
        begin
            for (int k = 0; k < WIDTH; k++)
            begin
                if (key_sync[k] == key_clean[k])
                begin
                    stable_cnt[k] <= '0;  // bounce back, start over
                end
                else if (stable_cnt[k] == CNT_LAST)
                begin
                    key_clean[k]  <= key_sync[k];  // held long enough, take it
                    stable_cnt[k] <= '0;
                end
                else
                begin
                    stable_cnt[k] <= stable_cnt[k] + CNT_W'(1);  // still differs
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/reset_request_pulser.sv
/* turns a rising edge on a synchronized request into a PULSE_CYCLES wide pulse
   edges arriving while the pulse is high are dropped, not queued */
`timescale 1ns/10ps
`default_nettype none

module reset_request_pulser
#(
    parameter int PULSE_CYCLES = 2
)
(
    input  logic fpga_clk_50,
    input  logic hps_fpga_reset_n,
    input  logic request,
    output logic pulse
);

    localparam int CNT_W = fpga_support_pkg::counter_width(PULSE_CYCLES);

    logic             request_q;  // last cycle's level for edge detect
    logic [CNT_W-1:0] remain;     // cycles of pulse still to go
    logic             rise;

    assign rise = request & ~request_q;

    // ====================================================================
    // edge detect and stretch
    // ====================================================================
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            request_q <= 1'b0;
            remain    <= '0;
        end
        else
        begin
            request_q <= request;  // tracks even while busy so old edges expire
            if (remain != '0)
            begin
                remain <= remain - CNT_W'(1);  // busy, ignore rise
            end
            else if (rise)
            begin
                remain <= CNT_W'(PULSE_CYCLES);  // pulse starts next cycle
            end
        end
    end

    // high for exactly PULSE_CYCLES cycles after the load
    assign pulse = (remain != '0);

endmodule

`default_nettype wire

//--- testbench/fpga_support_patterns.txt
// columns, all hex: key sw led_soft reset_req hold_cycles expected_key_clean
// keys are active low, one step per line, hold 0 ends the list
f 000 000 0 30 f  // idle, heartbeat free running
e 155 000 0 0c e  // key 0 pressed
f 155 000 0 0c f  // released
d 155 000 0 05 f  // 5 cycle glitch on key 1, filtered
f 155 000 0 0c f
0 2aa 2aa 0 10 0  // all keys pressed
7 2aa 2aa 0 0c 7  // keys 0 to 2 released
b 3ff 154 0 0c b  // key 2 down, key 3 up
f 000 000 0 0c f
f 000 000 1 0c f  // cold request
f 000 000 0 0c f
f 000 000 2 08 f  // warm request
f 000 000 0 08 f
f 000 000 4 06 f  // debug request
f 000 000 0 04 f
f 000 000 4 06 f  // second edge inside the debug pulse
f 000 000 0 30 f
f 0f0 000 7 0c f  // all three at once
f 0f0 000 0 30 f
e 30f 201 0 0c e  // software drives led 0
f 000 000 0 20 f

//--- testbench/tb_fpga_support.sv
/* testbench for fpga_support_top with short debounce and heartbeat times
   reads testbench/fpga_support_patterns.txt, so run it from the project root */
`timescale 1ns/10ps
`default_nettype none

module tb_fpga_support;

    localparam int CLK_PERIOD    = 40;            // ns
    localparam int HALF_PERIOD   = 20;            // heartbeat toggle interval
    localparam int DEBOUNCE      = 8;             // key debounce time in cycles
    localparam int SYNC_DEPTH    = 2;
    localparam int KEY_LATENCY   = SYNC_DEPTH + DEBOUNCE;  // drive edge to key_clean
    localparam int MAX_STEPS     = 64;
    localparam int EXTRA_STEPS   = 6;             // random led_soft steps
    localparam int EXTRA_HOLD    = 12;
    localparam int PULSE_LEN [3] = '{6, 2, 32};   // cold, warm, debug

    logic        fpga_clk_50 = 1'b0;
    logic        hps_fpga_reset_n;
    logic [3:0]  key;
    logic [9:0]  sw;
    logic [9:0]  led_soft;
    logic [2:0]  reset_req;
    logic [9:0]  ledr;
    logic [3:0]  key_clean;
    logic [2:0]  reset_pulse;
    logic [27:0] stm_hw_events;
    logic [11:0] pattern_mem [6*MAX_STEPS];       // six fields per step

    int cycle_count = 0;
    int key_errors = 0;
    int trace_errors = 0;
    int pulse_errors = 0;
    int led_errors = 0;
    int watchdog_ns = 0;
    int t_now = 0;                                // step start, in cycles
    int last_start [3] = '{-1000, -1000, -1000};  // last accepted request edge
    int expected_pulses [3] = '{0, 0, 0};
    int pulses_seen [3] = '{0, 0, 0};
    int run_len [3] = '{0, 0, 0};
    int last_toggle = -1;                         // -1 when spacing unknown
    int toggles_checked = 0;
    logic [2:0] prev_req = '0;
    logic [3:0] key_exp_prev = 4'hf;              // key_clean before the current step
    logic release_seen = 1'b0;
    logic led0_prev = 1'b0;
    logic soft0_prev = 1'b0;

    fpga_support_top #(.DEBOUNCE_CYCLES(DEBOUNCE), .HEARTBEAT_HALF_PERIOD(HALF_PERIOD)) u_dut
    (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .key              (key),
        .sw               (sw),
        .led_soft         (led_soft),
        .reset_req        (reset_req),
        .ledr             (ledr),
        .key_clean        (key_clean),
        .reset_pulse      (reset_pulse),
        .stm_hw_events    (stm_hw_events)
    );

    always #(CLK_PERIOD/2) fpga_clk_50 = ~fpga_clk_50;
    always @(posedge fpga_clk_50) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // drive one step, hold it, then check key_clean and the trace word
    task automatic apply_step(input logic [3:0] key_val, input logic [9:0] sw_val,
                              input logic [9:0] led_val, input logic [2:0] req_val,
                              input int hold, input logic [3:0] exp_key);
        logic [27:0] exp_trace;
        logic [3:0]  want_key;
        @(posedge fpga_clk_50);
        key       <= key_val;
        sw        <= sw_val;
        led_soft  <= led_val;
        reset_req <= req_val;
        for (int ch = 0; ch < 3; ch++)
        begin
            // rise starts a pulse unless the previous one is still high
            if (req_val[ch] && !prev_req[ch] && (t_now - last_start[ch] > PULSE_LEN[ch]))
            begin
                expected_pulses[ch]++;
                last_start[ch] = t_now;
            end
        end
        prev_req = req_val;
        t_now += hold;
        for (int c = 0; c < hold - 1; c++)
        begin
            @(negedge fpga_clk_50);
            want_key = (c < KEY_LATENCY) ? key_exp_prev : exp_key;  // c edges since drive
            if (key_clean !== want_key)
            begin
                $display("[FAIL] %0d ns: key_clean %h during step, expected %h", $time,
                         key_clean, want_key);
                key_errors++;
            end
        end
        @(negedge fpga_clk_50);
        if (key_clean !== exp_key)
        begin
            $display("[FAIL] %0d ns: key_clean %h, expected %h", $time, key_clean, exp_key);
            key_errors++;
        end
        key_exp_prev = exp_key;
        exp_trace = {5'b0, sw_val, led_val[8:0], exp_key};  // upper bits zero
        if (hold > SYNC_DEPTH && stm_hw_events !== exp_trace)
        begin
            $display("[FAIL] %0d ns: stm_hw_events %h, expected %h", $time, stm_hw_events,
                     exp_trace);
            trace_errors++;
        end
    endtask

    // ====================================================================
    // monitor: led mirror, pulse widths, heartbeat spacing
    // ====================================================================
    always @(negedge fpga_clk_50)
    begin
        if (hps_fpga_reset_n)
        begin
            if (ledr[9:1] !== led_soft[9:1] || (led_soft[0] && ledr[0] !== 1'b1))
            begin
                $display("[FAIL] %0d ns: ledr %h with led_soft %h", $time, ledr, led_soft);
                led_errors++;
            end
            for (int ch = 0; ch < 3; ch++)
            begin
                if (reset_pulse[ch])
                    run_len[ch]++;                  // count high cycles
                else if (run_len[ch] != 0)
                begin
                    if (run_len[ch] != PULSE_LEN[ch])
                    begin
                        $display("[FAIL] %0d ns: pulse %0d lasted %0d cycles, expected %0d",
                                 $time, ch, run_len[ch], PULSE_LEN[ch]);
                        pulse_errors++;
                    end
                    pulses_seen[ch]++;
                    run_len[ch] = 0;
                end
            end
            if (!release_seen)
            begin
                release_seen = 1'b1;
                last_toggle  = cycle_count;         // divider starts here
            end
            else if (led_soft[0] || soft0_prev)
                last_toggle = -1;                   // software owns led 0
            else if (ledr[0] !== led0_prev)
            begin
                if (last_toggle >= 0 && cycle_count - last_toggle != HALF_PERIOD)
                begin
                    $display("[FAIL] %0d ns: heartbeat toggled after %0d cycles", $time,
                             cycle_count - last_toggle);
                    led_errors++;
                end
                if (last_toggle >= 0)
                    toggles_checked++;
                last_toggle = cycle_count;
            end
            led0_prev  = ledr[0];
            soft0_prev = led_soft[0];
        end
    end

    initial
    begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("Test failed");
        $finish;
    end

    // ====================================================================
    // main sequence
    // ====================================================================
    initial
    begin
        int steps;
        int sum_holds;
        logic [31:0] rnd;
        hps_fpga_reset_n = 1'b0;
        key              = '1;                      // keys released
        sw               = '0;
        led_soft         = '0;
        reset_req        = '0;
        steps            = 0;
        sum_holds        = 0;
        rnd              = 32'h4396;
        for (int i = 0; i < 6*MAX_STEPS; i++)
            pattern_mem[i] = '0;
        $readmemh("testbench/fpga_support_patterns.txt", pattern_mem);
        while (steps < MAX_STEPS && pattern_mem[6*steps+4] != '0)
        begin
            sum_holds += int'(pattern_mem[6*steps+4]);
            steps++;
        end
        if (steps == 0)
        begin
            $display("pattern file held no steps");
            key_errors++;
        end
        watchdog_ns = (sum_holds + EXTRA_STEPS*EXTRA_HOLD + 200) * CLK_PERIOD;

        repeat (8) @(posedge fpga_clk_50);
        hps_fpga_reset_n <= 1'b1;
        @(negedge fpga_clk_50);
        if (key_clean !== 4'hf || reset_pulse !== 3'b000 || ledr[0] !== 1'b0)
        begin
            $display("[FAIL] %0d ns: after reset key_clean %h reset_pulse %b ledr0 %b", $time,
                     key_clean, reset_pulse, ledr[0]);
            key_errors++;
        end

        for (int s = 0; s < steps; s++)
            apply_step(pattern_mem[6*s][3:0], pattern_mem[6*s+1][9:0],
                       pattern_mem[6*s+2][9:0], pattern_mem[6*s+3][2:0],
                       int'(pattern_mem[6*s+4]), pattern_mem[6*s+5][3:0]);
        for (int e = 0; e < EXTRA_STEPS; e++)
        begin
            rnd = next_random(rnd);
            apply_step(4'hf, 10'h000, rnd[9:0], 3'b000, EXTRA_HOLD, 4'hf);  // keys idle
        end

        repeat (2) @(posedge fpga_clk_50);
        for (int ch = 0; ch < 3; ch++)
        begin
            if (pulses_seen[ch] != expected_pulses[ch] || run_len[ch] != 0)
            begin
                $display("[FAIL] %0d ns: channel %0d gave %0d pulses, expected %0d", $time,
                         ch, pulses_seen[ch], expected_pulses[ch]);
                pulse_errors++;
            end
        end
        if (toggles_checked == 0)
        begin
            $display("heartbeat never toggled twice with led_soft bit 0 low");
            led_errors++;
        end
        $display("errors: key %0d, trace %0d, pulse %0d, led %0d", key_errors, trace_errors,
                 pulse_errors, led_errors);
        if (key_errors + trace_errors + pulse_errors + led_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
